// File: design/myo_settings.svh
/* build constants of the motor board controller
   motor count, SPI word and frame sizes, SCK timing and the unmapped read value */
`ifndef MYO_SETTINGS_SVH
`define MYO_SETTINGS_SVH

// motor boards that share the SPI bus, each with its own slave select
`define MYO_NUM_MOTORS 6
// bits in one SPI word
`define MYO_WORD_BITS 16
// words swapped with a board in every frame
`define MYO_FRAME_WORDS 6
// system clock cycles in half an SCK period
`define MYO_SCK_HALF 2
// read value for unmapped selects and absent motors
`define MYO_BAD_READ 32'hDEADBEEF

`endif

// File: design/myo_pkg.sv
/* shared types: SPI word, motor index, host register selects,
   frame engine states and the per-motor feedback record */
`default_nettype none
`include "myo_settings.svh"

package myo_pkg;
	// one word on the SPI bus, also the width of the int16 host registers
	typedef logic signed [`MYO_WORD_BITS-1:0] word_t;
	// index of one board on the shared bus
	typedef logic [$clog2(`MYO_NUM_MOTORS)-1:0] motor_idx_t;
	// register select, carried in the upper byte of the host address
	typedef enum logic [7:0] {
		REG_PWM_REF       = 8'h00,
		REG_POSITION      = 8'h01,
		REG_VELOCITY      = 8'h02,
		REG_CURRENT       = 8'h03,
		REG_DISPLACEMENT  = 8'h04,
		REG_SPI_ENABLE    = 8'h05,
		REG_UPDATE_PERIOD = 8'h06,
		REG_SCAN_CYCLES   = 8'h07
	} reg_sel_e;
	// states of the frame engine
	typedef enum logic [2:0] {FS_IDLE, FS_LOAD, FS_SHIFT, FS_NEXT, FS_DONE} frame_state_e;
	// what one board reports back in a frame
	typedef struct packed {
		logic signed [31:0] position;
		word_t velocity;
		word_t current;
		word_t displacement;
	} motor_feedback_t;
endpackage

`default_nettype wire

// File: design/spi_word_if.sv
/* word handshake between the frame engine and the SPI shifter */
`timescale 1ns/1ps
`default_nettype none

interface spi_word_if;
	// one-cycle request to send tx_word, only while busy is low
	logic load;
	myo_pkg::word_t tx_word;
	// high while a word is on the wire
	logic busy;
	// one-cycle pulse when rx_word holds a complete word
	logic rx_valid;
	myo_pkg::word_t rx_word;

	// frame engine side
	modport master (output load, output tx_word, input busy, input rx_valid, input rx_word);
	// shifter side
	modport spi (input load, input tx_word, output busy, output rx_valid, output rx_word);
endinterface

`default_nettype wire

// File: design/myo_frame_if.sv
/* frame handshake between the scan sequencer and the frame engine */
`timescale 1ns/1ps
`default_nettype none

interface myo_frame_if;
	// one-cycle pulse, given only while busy is low
	logic start;
	// board being served, stable for the whole frame
	myo_pkg::motor_idx_t motor;
	myo_pkg::word_t pwm_ref;
	logic mirrored;
	// high from the cycle after start up to and including done
	logic busy;
	// one-cycle pulse after the last word, feedback valid with it
	logic done;
	myo_pkg::motor_feedback_t feedback;

	// the engine never needs the motor index, the select decode reads it at the top
	modport sequencer (
		output start, output motor, output pwm_ref, output mirrored,
		input busy, input done
	);
	modport engine (
		input start, input pwm_ref, input mirrored,
		output busy, output done, output feedback
	);
endinterface

`default_nettype wire

// File: design/spi_word_shifter.sv
/* SPI master shifter for one word, SCK idle low, MSB first,
   MOSI updated on the rising edge and MISO sampled on the falling edge */
`timescale 1ns/1ps
`default_nettype none
`include "myo_settings.svh"

module spi_word_shifter (
	input  wire        clock,
	input  wire        reset,
	spi_word_if.spi    spi,
	output logic       sck_o,
	output logic       mosi_o,
	input  wire        miso_i
);
	localparam int HALF_W = $clog2(`MYO_SCK_HALF + 1);
	localparam int BIT_W = $clog2(`MYO_WORD_BITS);
	localparam int MSB = `MYO_WORD_BITS - 1;

	logic [HALF_W-1:0] half_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic busy_q;
	logic rx_valid_q;
	logic edge_now;
	myo_pkg::word_t tx_shift;
	myo_pkg::word_t rx_shift;

	// SCK toggles whenever a half period has run out
	assign edge_now = busy_q && (half_cnt == HALF_W'(`MYO_SCK_HALF - 1));

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			busy_q <= 1'b0;
			rx_valid_q <= 1'b0;
			sck_o <= 1'b0;
			mosi_o <= 1'b0;
			half_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			rx_valid_q <= 1'b0;
			if (spi.load) begin
				busy_q <= 1'b1;
				half_cnt <= '0;
				bit_cnt <= '0;
			end else if (edge_now) begin
				half_cnt <= '0;
				sck_o <= ~sck_o;
				if (!sck_o) begin
					// rising edge puts the next bit on MOSI
					mosi_o <= tx_shift[MSB];
				end else begin
					// falling edge closes one bit, the last one ends the word
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(MSB)) begin
						busy_q <= 1'b0;
						rx_valid_q <= 1'b1;
					end
				end
			end else if (busy_q) begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// data shift registers follow the same edges as the control above
	always_ff @(posedge clock) begin
		if (spi.load) begin
			tx_shift <= spi.tx_word;
		end else if (edge_now && !sck_o) begin
			tx_shift <= tx_shift << 1;
		end else if (edge_now && sck_o) begin
			rx_shift <= {rx_shift[MSB-1:0], miso_i};
		end
	end

	assign spi.busy = busy_q;
	assign spi.rx_valid = rx_valid_q;
	assign spi.rx_word = rx_shift;
endmodule

`default_nettype wire

// File: design/myo_frame_exchange.sv
/* frame engine: sends the PWM word and fills, collects the board reply
   into a feedback record and flags the end of the frame */
`timescale 1ns/1ps
`default_nettype none
`include "myo_settings.svh"

module myo_frame_exchange (
	input  wire          clock,
	input  wire          reset,
	myo_frame_if.engine  frame,
	spi_word_if.master   spi
);
	localparam int WCNT_W = $clog2(`MYO_FRAME_WORDS);
	localparam int LAST_WORD = `MYO_FRAME_WORDS - 1;

	myo_pkg::frame_state_e state;
	logic [WCNT_W-1:0] word_cnt;
	logic mirrored_q;
	myo_pkg::word_t pwm_q;
	myo_pkg::motor_feedback_t fb_q;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= myo_pkg::FS_IDLE;
			word_cnt <= '0;
			mirrored_q <= 1'b0;
		end else begin
			case (state)
				myo_pkg::FS_IDLE: begin
					word_cnt <= '0;
					if (frame.start) begin
						// orientation is frozen for the whole frame
						mirrored_q <= frame.mirrored;
						state <= myo_pkg::FS_LOAD;
					end
				end
				myo_pkg::FS_LOAD: begin
					if (!spi.busy) begin
						state <= myo_pkg::FS_SHIFT;
					end
				end
				myo_pkg::FS_SHIFT: begin
					if (spi.rx_valid) begin
						state <= (word_cnt == WCNT_W'(LAST_WORD)) ? myo_pkg::FS_DONE
							: myo_pkg::FS_NEXT;
					end
				end
				myo_pkg::FS_NEXT: begin
					word_cnt <= word_cnt + 1'b1;
					state <= myo_pkg::FS_LOAD;
				end
				default: state <= myo_pkg::FS_IDLE;
			endcase
		end
	end

	// the reply of word 0 is stale data from the board and is dropped
	always_ff @(posedge clock) begin
		if (state == myo_pkg::FS_IDLE && frame.start) begin
			pwm_q <= frame.pwm_ref;
		end
		if (state == myo_pkg::FS_SHIFT && spi.rx_valid) begin
			case (word_cnt)
				WCNT_W'(1): fb_q.position[31:16] <= spi.rx_word;
				WCNT_W'(2): fb_q.position[15:0] <= spi.rx_word;
				WCNT_W'(3): fb_q.velocity <= spi.rx_word;
				WCNT_W'(4): fb_q.current <= spi.rx_word;
				WCNT_W'(5): fb_q.displacement <= mirrored_q ? -spi.rx_word : spi.rx_word;
				default: ;
			endcase
		end
	end

	// only word 0 carries the PWM reference, the rest are zero fill
	assign spi.tx_word = (word_cnt == '0) ? pwm_q : '0;
	assign spi.load = (state == myo_pkg::FS_LOAD) && !spi.busy;
	assign frame.busy = (state != myo_pkg::FS_IDLE);
	assign frame.done = (state == myo_pkg::FS_DONE);
	assign frame.feedback = fb_q;
endmodule

`default_nettype wire

// File: design/myo_scan_sequencer.sv
/* scan sequencer: walks the motors in order, paces each scan by the
   update period and measures the cycles between motor 0 starts */
`timescale 1ns/1ps
`default_nettype none
`include "myo_settings.svh"

module myo_scan_sequencer (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   spi_enable_i,
	input  wire [31:0]            update_period_i,
	input  myo_pkg::word_t        pwm_refs_i [0:`MYO_NUM_MOTORS-1],
	myo_frame_if.sequencer        frame,
	input  wire                   mirrored_i,
	output logic [31:0]           scan_cycles_o
);
	localparam myo_pkg::motor_idx_t LAST_MOTOR = myo_pkg::motor_idx_t'(`MYO_NUM_MOTORS - 1);

	myo_pkg::motor_idx_t motor_q;
	myo_pkg::motor_idx_t next_q;
	logic start_q;
	logic [31:0] period_cnt;
	logic frame_free;
	logic period_ok;
	logic launch;

	// done frees the engine one cycle early so the next start follows it directly
	assign frame_free = frame.done || (!frame.busy && !start_q);
	// only motor 0 waits for the period, a zero period always passes
	assign period_ok = (next_q != '0) || (period_cnt >= update_period_i);
	assign launch = spi_enable_i && frame_free && period_ok;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			start_q <= 1'b0;
			motor_q <= '0;
			next_q <= '0;
			period_cnt <= '0;
			scan_cycles_o <= '0;
		end else begin
			start_q <= launch;
			// saturate so a long pause cannot wrap back below the period
			if (period_cnt != '1) begin
				period_cnt <= period_cnt + 1'b1;
			end
			if (launch) begin
				motor_q <= next_q;
				next_q <= (next_q == LAST_MOTOR) ? '0 : next_q + 1'b1;
				if (next_q == '0) begin
					// period_cnt holds the distance to the previous motor 0 start
					scan_cycles_o <= period_cnt;
					period_cnt <= 32'd1;
				end
			end
		end
	end

	assign frame.start = start_q;
	assign frame.motor = motor_q;
	assign frame.pwm_ref = pwm_refs_i[motor_q];
	assign frame.mirrored = mirrored_i;
endmodule

`default_nettype wire

// File: design/myo_host_regs.sv
/* host register bank: bus decode, writable settings, per-motor feedback
   store and the registered read path with its one wait cycle */
`timescale 1ns/1ps
`default_nettype none
`include "myo_settings.svh"

module myo_host_regs (
	input  wire                       clock,
	input  wire                       reset,
	input  wire [15:0]                address_i,
	input  wire                       read_i,
	input  wire                       write_i,
	input  wire [31:0]                writedata_i,
	output logic [31:0]               readdata_o,
	output logic                      waitrequest_o,
	input  wire                       done_i,
	input  myo_pkg::motor_idx_t       motor_i,
	input  myo_pkg::motor_feedback_t  feedback_i,
	input  wire [31:0]                scan_cycles_i,
	output logic                      spi_enable_o,
	output logic [31:0]               update_period_o,
	output myo_pkg::word_t            pwm_refs_o [0:`MYO_NUM_MOTORS-1]
);
	localparam int W = `MYO_WORD_BITS;

	myo_pkg::reg_sel_e sel;
	myo_pkg::motor_idx_t idx;
	logic in_range;
	logic rd_phase;
	logic [31:0] rd_value;
	myo_pkg::motor_feedback_t fb_mem [0:`MYO_NUM_MOTORS-1];

	// int16 registers read back sign extended
	function automatic logic [31:0] sext_word(input myo_pkg::word_t v);
		return {{(32 - W){v[W-1]}}, v};
	endfunction

	// upper address byte picks the register, lower byte the motor
	assign sel = myo_pkg::reg_sel_e'(address_i[15:8]);
	assign idx = address_i[$bits(myo_pkg::motor_idx_t)-1:0];
	assign in_range = (address_i[7:0] < 8'(`MYO_NUM_MOTORS));

	always_comb begin
		case (sel)
			myo_pkg::REG_PWM_REF:       rd_value = sext_word(pwm_refs_o[idx]);
			myo_pkg::REG_POSITION:      rd_value = fb_mem[idx].position;
			myo_pkg::REG_VELOCITY:      rd_value = sext_word(fb_mem[idx].velocity);
			myo_pkg::REG_CURRENT:       rd_value = sext_word(fb_mem[idx].current);
			myo_pkg::REG_DISPLACEMENT:  rd_value = sext_word(fb_mem[idx].displacement);
			myo_pkg::REG_SPI_ENABLE:    rd_value = {31'd0, spi_enable_o};
			myo_pkg::REG_UPDATE_PERIOD: rd_value = update_period_o;
			myo_pkg::REG_SCAN_CYCLES:   rd_value = scan_cycles_i;
			default:                    rd_value = `MYO_BAD_READ;
		endcase
		// a per-motor select aimed past the last board reads as unmapped
		if (!in_range && sel inside {myo_pkg::REG_PWM_REF, myo_pkg::REG_POSITION,
				myo_pkg::REG_VELOCITY, myo_pkg::REG_CURRENT, myo_pkg::REG_DISPLACEMENT}) begin
			rd_value = `MYO_BAD_READ;
		end
	end

	// first read cycle stalls the host while readdata is captured
	assign waitrequest_o = read_i && !rd_phase;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rd_phase <= 1'b0;
			readdata_o <= '0;
			spi_enable_o <= 1'b0;
			update_period_o <= '0;
			for (int m = 0; m < `MYO_NUM_MOTORS; m++) begin
				pwm_refs_o[m] <= '0;
				fb_mem[m] <= '0;
			end
		end else begin
			rd_phase <= read_i && !rd_phase;
			if (read_i && !rd_phase) begin
				readdata_o <= rd_value;
			end
			// the finished frame belongs to the motor still shown with done
			if (done_i) begin
				fb_mem[motor_i] <= feedback_i;
			end
			// writes never wait, read-only and unmapped selects fall through
			if (write_i) begin
				case (sel)
					myo_pkg::REG_PWM_REF: begin
						if (in_range) begin
							pwm_refs_o[idx] <= writedata_i[W-1:0];
						end
					end
					myo_pkg::REG_SPI_ENABLE:    spi_enable_o <= writedata_i[0];
					myo_pkg::REG_UPDATE_PERIOD: update_period_o <= writedata_i;
					default: ;
				endcase
			end
		end
	end
endmodule

`default_nettype wire

// File: design/myo_control_top.sv
/* top level of the motor board controller: register bank, scan sequencer,
   frame engine, SPI shifter and the per-board slave select decode */
`timescale 1ns/1ps
`default_nettype none
`include "myo_settings.svh"

module myo_control_top (
	input  wire                         clock,
	input  wire                         reset,
	input  wire [15:0]                  address_i,
	input  wire                         read_i,
	input  wire                         write_i,
	input  wire [31:0]                  writedata_i,
	output wire [31:0]                  readdata_o,
	output wire                         waitrequest_o,
	output wire [`MYO_NUM_MOTORS-1:0]   ss_n_o,
	output wire                         sck_o,
	output wire                         mosi_o,
	input  wire                         miso_i,
	input  wire                         mirrored_i
);
	logic spi_enable;
	logic [31:0] update_period;
	logic [31:0] scan_cycles;
	myo_pkg::word_t pwm_refs [0:`MYO_NUM_MOTORS-1];

	spi_word_if spi_if ();
	myo_frame_if frame_if ();

	myo_host_regs host_regs_i (
		.clock(clock), .reset(reset),
		.address_i(address_i), .read_i(read_i), .write_i(write_i),
		.writedata_i(writedata_i), .readdata_o(readdata_o), .waitrequest_o(waitrequest_o),
		.done_i(frame_if.done), .motor_i(frame_if.motor), .feedback_i(frame_if.feedback),
		.scan_cycles_i(scan_cycles), .spi_enable_o(spi_enable),
		.update_period_o(update_period), .pwm_refs_o(pwm_refs)
	);

	myo_scan_sequencer scan_sequencer_i (
		.clock(clock), .reset(reset),
		.spi_enable_i(spi_enable), .update_period_i(update_period),
		.pwm_refs_i(pwm_refs), .frame(frame_if.sequencer),
		.mirrored_i(mirrored_i), .scan_cycles_o(scan_cycles)
	);

	myo_frame_exchange frame_exchange_i (
		.clock(clock), .reset(reset),
		.frame(frame_if.engine), .spi(spi_if.master)
	);

	spi_word_shifter spi_word_shifter_i (
		.clock(clock), .reset(reset), .spi(spi_if.spi),
		.sck_o(sck_o), .mosi_o(mosi_o), .miso_i(miso_i)
	);

	// only the board being served sees its select low, and only while the frame runs
	for (genvar g = 0; g < `MYO_NUM_MOTORS; g++) begin : g_ss
		assign ss_n_o[g] = ~(frame_if.busy && (frame_if.motor == myo_pkg::motor_idx_t'(g)));
	end
endmodule

`default_nettype wire

// File: tb/motor_board_model.sv
/* SPI slave model of all motor boards on the bus: answers each frame with
   feedback derived from the motor index and checks the words it receives */
`timescale 1ns/1ps
`default_nettype none
`include "myo_settings.svh"

module motor_board_model (
	input  wire [`MYO_NUM_MOTORS-1:0]        ss_n_i,
	input  wire                              sck_i,
	input  wire                              mosi_i,
	output wire                              miso_o,
	input  wire [`MYO_NUM_MOTORS-1:0][15:0]  pwm_expect_i,
	output wire [`MYO_NUM_MOTORS-1:0][15:0]  served_o,
	output wire                              error_o
);
	localparam int WORD_BITS = `MYO_WORD_BITS;
	localparam int FRAME_BITS = `MYO_FRAME_WORDS * `MYO_WORD_BITS;

	logic [`MYO_NUM_MOTORS-1:0][15:0] served = '0;
	logic error_flag = 1'b0;
	logic miso_q = 1'b0;
	logic frame_open = 1'b0;
	string error_text = "";
	int active;
	int bit_idx;
	int word;
	logic [31:0] position;
	logic [15:0] rx_word;
	logic [15:0] expected;
	logic [FRAME_BITS-1:0] reply;

	// all selects back high close the frame
	always @(ss_n_i) begin
		if (ss_n_i == '1) frame_open = 1'b0;
	end

	// the first rising SCK edge of a frame picks the board, k counts its frames including this one
	// every rising edge puts the next reply bit on MISO, MSB first
	always @(posedge sck_i) begin
		if (ss_n_i != '1) begin
			if (!frame_open) begin
				active = 0;
				for (int m = 0; m < `MYO_NUM_MOTORS; m++) begin
					if (!ss_n_i[m]) active = m;
				end
				served[active] = served[active] + 1'b1;
				position = 32'h10000 * (active + 1) + 32'(served[active]);
				// word 0 of the reply is a dummy the master drops
				reply = {16'h0000, position, 16'(100 + active), 16'(200 + active),
					16'(300 + active)};
				bit_idx = 0;
				frame_open = 1'b1;
			end
			miso_q <= reply[FRAME_BITS - 1 - bit_idx];
		end
	end

	// MOSI is sampled on the falling edge, word 0 must carry the PWM reference
	always @(negedge sck_i) begin
		if (ss_n_i != '1) begin
			rx_word = {rx_word[14:0], mosi_i};
			bit_idx = bit_idx + 1;
			if (bit_idx % WORD_BITS == 0) begin
				word = bit_idx / WORD_BITS - 1;
				expected = (word == 0) ? pwm_expect_i[active] : 16'h0000;
				assert (rx_word === expected) else begin
					error_text = $sformatf("ERROR at %0t ns: MOSI word %0d to motor %0d is 0x%h, expected 0x%h",
						$time, word, active, rx_word, expected);
					error_flag = 1'b1;
				end
			end
		end
	end

	assign miso_o = miso_q;
	assign served_o = served;
	assign error_o = error_flag;
endmodule

`default_nettype wire

// File: tb/tb_myo_control.sv
/* testbench of the motor board controller: clock, reset, host bus tasks,
   register, scan order, feedback, mirroring and scan period checks */
`timescale 1ns/1ps
`default_nettype none
`include "myo_settings.svh"

module tb_myo_control;
	localparam int N = `MYO_NUM_MOTORS;
	localparam int WAIT_LIMIT = 100;
	localparam int SCAN_LIMIT = 40000;

	logic clock;
	logic reset;
	logic [15:0] address;
	logic read;
	logic write;
	logic [31:0] writedata;
	logic mirrored;
	logic spi_quiet;
	wire [31:0] readdata;
	wire waitrequest;
	wire [N-1:0] ss_n;
	wire sck;
	wire mosi;
	wire miso;
	wire board_error;
	wire [N-1:0][15:0] served;
	logic [N-1:0][15:0] pwm_expect;
	logic [N-1:0] ss_n_prev = '1;
	int next_motor = 0;
	logic [31:0] rdata;
	logic [31:0] wdata;
	int base;
	int k;

	myo_control_top myo_control_top_i (
		.clock(clock), .reset(reset),
		.address_i(address), .read_i(read), .write_i(write),
		.writedata_i(writedata), .readdata_o(readdata), .waitrequest_o(waitrequest),
		.ss_n_o(ss_n), .sck_o(sck), .mosi_o(mosi), .miso_i(miso), .mirrored_i(mirrored)
	);

	motor_board_model board_model_i (
		.ss_n_i(ss_n), .sck_i(sck), .mosi_i(mosi), .miso_o(miso),
		.pwm_expect_i(pwm_expect), .served_o(served), .error_o(board_error)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic expect_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else stop_with_failure($sformatf(
			"ERROR at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp));
	endtask

	// upper byte is the register select, lower byte the motor
	function automatic logic [15:0] address_of(input logic [7:0] sel, input int motor);
		return {sel, 8'(motor)};
	endfunction

	task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
		int waited;
		@(posedge clock);
		#1;
		address = addr;
		writedata = data;
		write = 1'b1;
		waited = 0;
		@(negedge clock);
		while (waitrequest) begin
			if (waited >= WAIT_LIMIT) stop_with_failure("host write stalled by waitrequest");
			waited++;
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		write = 1'b0;
	endtask

	// readdata is taken in the cycle where waitrequest has dropped
	task automatic host_read(input logic [15:0] addr, output logic [31:0] data);
		int waited;
		@(posedge clock);
		#1;
		address = addr;
		read = 1'b1;
		waited = 0;
		@(negedge clock);
		while (waitrequest) begin
			if (waited >= WAIT_LIMIT) stop_with_failure("host read never released waitrequest");
			waited++;
			@(negedge clock);
		end
		data = readdata;
		@(posedge clock);
		#1;
		read = 1'b0;
	endtask

	task automatic wait_for_frames(input int motor, input int target);
		int waited;
		waited = 0;
		while (served[motor] < target) begin
			if (waited >= SCAN_LIMIT) stop_with_failure($sformatf(
				"motor %0d did not reach %0d frames in time", motor, target));
			waited++;
			@(negedge clock);
		end
	endtask

	// one board at a time, nothing selected while SPI is off, and a clean model
	assert property (@(posedge clock) disable iff (reset) $countones(~ss_n) <= 1)
		else stop_with_failure($sformatf(
			"ERROR at %0t ns: ss_n_o is %b, expected at most one bit low", $time, ss_n));
	assert property (@(posedge clock) disable iff (reset) spi_quiet |-> (ss_n == '1))
		else stop_with_failure("a slave select fell while SPI was disabled");
	assert property (@(posedge clock) !board_error)
		else stop_with_failure(board_model_i.error_text);

	// selects must fall in motor order and wrap around
	always @(negedge clock) begin
		if (!reset) begin
			for (int m = 0; m < N; m++) begin
				if (ss_n_prev[m] && !ss_n[m]) begin
					assert (m == next_motor) else stop_with_failure($sformatf(
						"ERROR at %0t ns: selected motor is %0d, expected %0d", $time, m, next_motor));
					next_motor = (m + 1) % N;
				end
			end
		end
		ss_n_prev = ss_n;
	end

	initial begin
		void'($urandom(31));
		reset = 1'b1;
		read = 1'b0;
		write = 1'b0;
		address = '0;
		writedata = '0;
		mirrored = 1'b0;
		spi_quiet = 1'b1;
		pwm_expect = '0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;

		// idle state after reset, and a write to a read-only register is dropped
		expect_value("ss_n_o", 32'(ss_n), 32'({N{1'b1}}));
		expect_value("sck_o", 32'(sck), 32'd0);
		expect_value("waitrequest_o", 32'(waitrequest), 32'd0);
		host_read(address_of(myo_pkg::REG_SPI_ENABLE, 0), rdata);
		expect_value("SPI_ENABLE", rdata, 32'd0);
		host_read(address_of(myo_pkg::REG_UPDATE_PERIOD, 0), rdata);
		expect_value("UPDATE_PERIOD", rdata, 32'd0);
		host_write(address_of(myo_pkg::REG_SCAN_CYCLES, 0), 32'h1234);
		host_read(address_of(myo_pkg::REG_SCAN_CYCLES, 0), rdata);
		expect_value("SCAN_CYCLES", rdata, 32'd0);
		for (int m = 0; m < N; m++) begin
			host_read(address_of(myo_pkg::REG_PWM_REF, m), rdata);
			expect_value($sformatf("PWM_REF[%0d]", m), rdata, 32'd0);
		end

		// random PWM references, only the low half lands and reads back sign extended
		for (int m = 0; m < N; m++) begin
			wdata = $urandom;
			host_write(address_of(myo_pkg::REG_PWM_REF, m), wdata);
			pwm_expect[m] = wdata[15:0];
		end
		host_write(address_of(myo_pkg::REG_PWM_REF, N), $urandom);
		for (int m = 0; m < N; m++) begin
			host_read(address_of(myo_pkg::REG_PWM_REF, m), rdata);
			expect_value($sformatf("PWM_REF[%0d]", m), rdata,
				{{16{pwm_expect[m][15]}}, pwm_expect[m]});
		end
		host_read(address_of(myo_pkg::REG_PWM_REF, N), rdata);
		expect_value("PWM_REF[out of range]", rdata, 32'hDEADBEEF);
		host_read(address_of(myo_pkg::REG_POSITION, N), rdata);
		expect_value("POSITION[out of range]", rdata, 32'hDEADBEEF);
		host_read(address_of(8'h08, 0), rdata);
		expect_value("unmapped select 0x08", rdata, 32'hDEADBEEF);
		host_read(address_of(8'hFF, 0), rdata);
		expect_value("unmapped select 0xFF", rdata, 32'hDEADBEEF);

		// scanning, feedback read after every board has finished a frame
		spi_quiet = 1'b0;
		host_write(address_of(myo_pkg::REG_SPI_ENABLE, 0), 32'd1);
		wait_for_frames(N - 1, 2);
		for (int m = 0; m < N; m++) begin
			host_read(address_of(myo_pkg::REG_POSITION, m), rdata);
			k = int'(rdata) - 32'h10000 * (m + 1);
			assert (k >= 1 && k <= served[m]) else stop_with_failure($sformatf(
				"ERROR at %0t ns: POSITION[%0d] is 0x%h, expected 0x%h plus 1 to %0d",
				$time, m, rdata, 32'h10000 * (m + 1), served[m]));
			host_read(address_of(myo_pkg::REG_VELOCITY, m), rdata);
			expect_value($sformatf("VELOCITY[%0d]", m), rdata, 32'(100 + m));
			host_read(address_of(myo_pkg::REG_CURRENT, m), rdata);
			expect_value($sformatf("CURRENT[%0d]", m), rdata, 32'(200 + m));
			host_read(address_of(myo_pkg::REG_DISPLACEMENT, m), rdata);
			expect_value($sformatf("DISPLACEMENT[%0d]", m), rdata, 32'(300 + m));
		end

		// three more frames of the last board cover a whole scan started while mirrored
		mirrored = 1'b1;
		base = served[N - 1];
		wait_for_frames(N - 1, base + 3);
		for (int m = 0; m < N; m++) begin
			host_read(address_of(myo_pkg::REG_DISPLACEMENT, m), rdata);
			expect_value($sformatf("DISPLACEMENT[%0d]", m), rdata, 32'(-(300 + m)));
		end
		mirrored = 1'b0;

		// a period longer than a scan sets the spacing of motor 0 starts
		host_write(address_of(myo_pkg::REG_UPDATE_PERIOD, 0), 32'd5000);
		base = served[0];
		wait_for_frames(0, base + 3);
		host_read(address_of(myo_pkg::REG_SCAN_CYCLES, 0), rdata);
		expect_value("SCAN_CYCLES", rdata, 32'd5000);
		host_write(address_of(myo_pkg::REG_SPI_ENABLE, 0), 32'd0);

		$display("Simulation finished: PASS");
		$finish;
	end
endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/myo_pkg.sv
design/spi_word_if.sv
design/myo_frame_if.sv
design/spi_word_shifter.sv
design/myo_frame_exchange.sv
design/myo_scan_sequencer.sv
design/myo_host_regs.sv
design/myo_control_top.sv
tb/motor_board_model.sv
tb/tb_myo_control.sv
